/* hdl/ialu_arch_pkg.sv */
/*
 * IALU architecture package
 * Data word width shared by the design and its testbench
 */

`default_nettype none

package ialu_arch_pkg;

    // ------------------------------------------------------------------------
    // Data path width
    // ------------------------------------------------------------------------

    // Default XLEN of every IALU module
    // Any even width of 8 or more is supported
    localparam int XLEN_DEFAULT = 32;

endpackage : ialu_arch_pkg

`default_nettype wire

/* hdl/ialu_cmd_pkg.sv */
/*
 * IALU command package
 * Command opcodes, multiplier FSM states and the multiply classifier
 */

`default_nettype none

package ialu_cmd_pkg;

    // ------------------------------------------------------------------------
    // ALU commands
    // ------------------------------------------------------------------------

    typedef enum logic [4:0] {
        IALU_CMD_NONE,          // No operation, result 0
        IALU_CMD_AND,
        IALU_CMD_OR,
        IALU_CMD_XOR,
        IALU_CMD_ADD,
        IALU_CMD_SUB,
        IALU_CMD_SUB_LT,        // Signed less than
        IALU_CMD_SUB_LTU,       // Unsigned less than
        IALU_CMD_SUB_EQ,
        IALU_CMD_SUB_NE,
        IALU_CMD_SUB_GE,        // Signed greater or equal
        IALU_CMD_SUB_GEU,       // Unsigned greater or equal
        IALU_CMD_SLL,
        IALU_CMD_SRL,
        IALU_CMD_SRA,
        IALU_CMD_MUL,           // Low half
        IALU_CMD_MULH,          // High half, signed x signed
        IALU_CMD_MULHSU,        // High half, signed x unsigned
        IALU_CMD_MULHU          // High half, unsigned x unsigned
    } ialu_cmd_e;

    // Iterative multiplier FSM
    typedef enum logic {
        MDU_IDLE,               // Waiting, first product bit
        MDU_ITER                // Remaining product bits
    } mdu_state_e;

    // True for the four multiply commands
    function automatic logic ialu_cmd_is_mul(input ialu_cmd_e cmd);
        return (cmd == IALU_CMD_MUL)    | (cmd == IALU_CMD_MULH)
             | (cmd == IALU_CMD_MULHSU) | (cmd == IALU_CMD_MULHU);
    endfunction

endpackage : ialu_cmd_pkg

`default_nettype wire

/* hdl/ialu_main_adder.sv */
/*
 * IALU main adder
 * Add or subtract with flags, selects the comparison outcome
 */

`timescale 1ns/100ps
`default_nettype none

module ialu_main_adder
    import ialu_arch_pkg::*, ialu_cmd_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  wire logic [XLEN-1:0] op1_i,     // 1st operand
    input  wire logic [XLEN-1:0] op2_i,     // 2nd operand
    input  wire ialu_cmd_e       cmd_i,     // ALU command
    output logic      [XLEN-1:0] sum_o,     // Sum or difference
    output logic                 cmp_o      // Comparison outcome
);

    logic [XLEN:0] sum_res;                 // MSB is carry / borrow
    logic          flag_c;                  // Carry
    logic          flag_z;                  // Zero
    logic          flag_s;                  // Sign
    logic          flag_o;                  // Overflow of op1 - op2
    logic          pos_ovf;
    logic          neg_ovf;

    // ------------------------------------------------------------------------
    // Adder and flags
    // ------------------------------------------------------------------------

    // Everything but ADD subtracts, comparisons included
    assign sum_res = (cmd_i != IALU_CMD_ADD) ? ({1'b0, op1_i} - {1'b0, op2_i})
                                             : ({1'b0, op1_i} + {1'b0, op2_i});

    // Positive minus negative gives negative, and the reverse
    assign pos_ovf = ~op1_i[XLEN-1] &  op2_i[XLEN-1] &  sum_res[XLEN-1];
    assign neg_ovf =  op1_i[XLEN-1] & ~op2_i[XLEN-1] & ~sum_res[XLEN-1];

    assign flag_c = sum_res[XLEN];          // Set when op1 < op2 unsigned
    assign flag_z = ~|sum_res[XLEN-1:0];
    assign flag_s = sum_res[XLEN-1];
    assign flag_o = pos_ovf | neg_ovf;

    assign sum_o  = sum_res[XLEN-1:0];

    // ------------------------------------------------------------------------
    // Comparison outcome
    // ------------------------------------------------------------------------

    always_comb begin
        case (cmd_i)
            IALU_CMD_SUB_LT  : cmp_o =   flag_s ^ flag_o;
            IALU_CMD_SUB_LTU : cmp_o =   flag_c;
            IALU_CMD_SUB_EQ  : cmp_o =   flag_z;
            IALU_CMD_SUB_NE  : cmp_o =  ~flag_z;
            IALU_CMD_SUB_GE  : cmp_o = ~(flag_s ^ flag_o);
            IALU_CMD_SUB_GEU : cmp_o =  ~flag_c;
            default          : cmp_o = 1'b0;     // Not a comparison
        endcase
    end

endmodule : ialu_main_adder

`default_nettype wire

/* hdl/ialu_shift_logic.sv */
/*
 * IALU shift and logic unit
 * Barrel shifts by op2 and bitwise AND / OR / XOR
 */

`timescale 1ns/100ps
`default_nettype none

module ialu_shift_logic
    import ialu_arch_pkg::*, ialu_cmd_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  wire logic [XLEN-1:0] op1_i,     // Value to shift, 1st logic operand
    input  wire logic [XLEN-1:0] op2_i,     // Shift amount, 2nd logic operand
    input  wire ialu_cmd_e       cmd_i,     // ALU command
    output logic      [XLEN-1:0] res_o      // Shift / logic result
);

    localparam int SHAMT_W = $clog2(XLEN);  // Shift amount width

    logic        [SHAMT_W-1:0] shamt;
    logic signed [XLEN-1:0]    shft_op1;    // Signed view for SRA

    // ------------------------------------------------------------------------
    // Operand preparation
    // ------------------------------------------------------------------------

    assign shamt    = op2_i[SHAMT_W-1:0];   // Upper bits of op2 ignored
    assign shft_op1 = op1_i;

    // ------------------------------------------------------------------------
    // Result selection
    // ------------------------------------------------------------------------

    always_comb begin
        case (cmd_i)
            IALU_CMD_AND : res_o = op1_i & op2_i;
            IALU_CMD_OR  : res_o = op1_i | op2_i;
            IALU_CMD_XOR : res_o = op1_i ^ op2_i;
            IALU_CMD_SLL : res_o = op1_i << shamt;
            IALU_CMD_SRL : res_o = op1_i >> shamt;
            // Sign bit fills from the left
            IALU_CMD_SRA : res_o = shft_op1 >>> shamt;
            default      : res_o = '0;
        endcase
    end

endmodule : ialu_shift_logic

`default_nettype wire

/* hdl/ialu_mul_ctrl.sv */
/*
 * IALU multiplier control
 * Radix-2 multiply FSM, one-hot iteration counter and result ready
 */

`timescale 1ns/100ps
`default_nettype none

module ialu_mul_ctrl
    import ialu_arch_pkg::*, ialu_cmd_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            cmd_valid_i,   // Command valid level
    input  wire logic            mul_cmd_i,     // Command is a multiply
    input  wire logic [XLEN-1:0] op1_i,
    input  wire logic [XLEN-1:0] op2_i,
    output mdu_state_e           state_o,       // Current FSM state
    output logic                 iter_last_o,   // Final iteration cycle
    output logic                 acc_en_o,      // Datapath register update
    output logic                 res_rdy_o      // Result ready level
);

    // Counter starts one below the top, ITER runs XLEN-1 cycles
    localparam logic [XLEN-2:0] CNT_INIT = {1'b1, {(XLEN-2){1'b0}}};

    mdu_state_e      state_ff;
    mdu_state_e      state_next;
    logic            fsm_idle;
    logic            ops_nonzero;           // Both operands nonzero
    logic            iter_req;              // Start iterating
    logic [XLEN-2:0] iter_cnt_ff;           // One-hot, shifts right
    logic [XLEN-2:0] iter_cnt_next;

    assign fsm_idle    = (state_ff == MDU_IDLE);
    assign ops_nonzero = (|op1_i) & (|op2_i);
    assign iter_req    = mul_cmd_i & ops_nonzero & fsm_idle;
    assign iter_last_o = ~fsm_idle & iter_cnt_ff[0];

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            state_ff <= MDU_IDLE;
        end else begin
            state_ff <= state_next;
        end
    end

    always_comb begin
        state_next = MDU_IDLE;              // Valid dropped, abort
        if (cmd_valid_i) begin
            case (state_ff)
                MDU_IDLE : state_next = iter_req    ? MDU_ITER : MDU_IDLE;
                MDU_ITER : state_next = iter_last_o ? MDU_IDLE : MDU_ITER;
            endcase
        end
    end

    assign state_o = state_ff;

    // ------------------------------------------------------------------------
    // Iteration counter and ready
    // ------------------------------------------------------------------------

    assign iter_cnt_next = fsm_idle ? CNT_INIT : (iter_cnt_ff >> 1);

    always_ff @(posedge clk) begin
        if (acc_en_o) begin
            iter_cnt_ff <= iter_cnt_next;
        end
    end

    // Zero operand answers in the issue cycle
    assign res_rdy_o = ~mul_cmd_i ? 1'b1
                     : fsm_idle   ? ~iter_req
                                  : iter_last_o;

    assign acc_en_o  = cmd_valid_i & ~res_rdy_o;

    // ------------------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------------------

    state_legal_a : assert property (
        @(posedge clk) disable iff (~rst_n)
        !$isunknown(state_ff)
    ) else $error("IALU MUL: unknown FSM state");

    iter_stay_a : assert property (
        @(posedge clk) disable iff (~rst_n)
        (~fsm_idle & ~iter_last_o & cmd_valid_i) |=> (state_ff == MDU_ITER)
    ) else $error("IALU MUL: left ITER before last iteration");

    iter_done_a : assert property (
        @(posedge clk) disable iff (~rst_n)
        iter_last_o |=> (state_ff == MDU_IDLE)
    ) else $error("IALU MUL: ITER held after last iteration");

endmodule : ialu_mul_ctrl

`default_nettype wire

/* hdl/ialu_mul_datapath.sv */
/*
 * IALU multiplier datapath
 * Radix-2 partial products, accumulator and high / low product registers
 */

`timescale 1ns/100ps
`default_nettype none

module ialu_mul_datapath
    import ialu_arch_pkg::*, ialu_cmd_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  wire logic            clk,
    input  wire logic [XLEN-1:0] op1_i,         // Multiplicand
    input  wire logic [XLEN-1:0] op2_i,         // Multiplier
    input  wire ialu_cmd_e       cmd_i,
    input  wire mdu_state_e      state_i,       // FSM state from control
    input  wire logic            iter_last_i,   // Sign weight cycle
    input  wire logic            acc_en_i,      // Register update
    output logic      [XLEN-1:0] mul_res_o      // Selected product half
);

    logic [1:0]             mul_sel;        // 00 MUL, 01 MULH, 10 MULHSU, 11 MULHU
    logic                   mul_hi;         // High half wanted
    logic                   op1_is_sgn;
    logic                   op2_is_sgn;
    logic                   fsm_idle;

    logic                   mul_bit;        // Current multiplier bit
    logic signed [XLEN:0]   mul_op1;        // Sign-extended multiplicand
    logic signed [1:0]      mul_op2;        // Bit with optional sign weight
    logic signed [XLEN:0]   part_prod;
    logic signed [XLEN:0]   acc_op;         // Sign-extended high register
    logic signed [XLEN:0]   acc_sum;

    logic [XLEN-1:0]        prod_hi_ff;
    logic [XLEN-1:0]        prod_lo_ff;     // Low product / remaining multiplier
    logic [XLEN-1:0]        prod_hi_next;
    logic [XLEN-1:0]        prod_lo_next;
    logic [XLEN-1:0]        lo_src;

    // ------------------------------------------------------------------------
    // Command decode
    // ------------------------------------------------------------------------

    assign mul_sel    = {(cmd_i == IALU_CMD_MULHU) | (cmd_i == IALU_CMD_MULHSU),
                         (cmd_i == IALU_CMD_MULHU) | (cmd_i == IALU_CMD_MULH)};
    assign mul_hi     = |mul_sel;
    assign op1_is_sgn = ~&mul_sel;          // Unsigned only for MULHU
    assign op2_is_sgn = ~mul_sel[1];        // MUL and MULH
    assign fsm_idle   = (state_i == MDU_IDLE);

    // ------------------------------------------------------------------------
    // Partial product and accumulator
    // ------------------------------------------------------------------------

    // Multiplier bits come from op2 at first, then from the low register
    assign lo_src  = fsm_idle ? op2_i : prod_lo_ff;
    assign mul_bit = lo_src[0];

    assign mul_op1 = $signed({op1_is_sgn & op1_i[XLEN-1], op1_i});
    // MSB of a signed multiplier counts negative
    assign mul_op2 = $signed({iter_last_i & op2_is_sgn & mul_bit, mul_bit});

    assign part_prod = mul_op1 * mul_op2;

    assign acc_op  = fsm_idle ? '0
                   : $signed({op1_is_sgn & prod_hi_ff[XLEN-1], prod_hi_ff});
    assign acc_sum = acc_op + part_prod;

    // Shift right by one bit per step
    assign prod_hi_next = acc_sum[XLEN:1];
    assign prod_lo_next = {acc_sum[0], lo_src[XLEN-1:1]};

    // ------------------------------------------------------------------------
    // Product registers
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (acc_en_i) begin
            prod_hi_ff <= prod_hi_next;
            prod_lo_ff <= prod_lo_next;
        end
    end

    // Final half is valid in the last ITER cycle
    assign mul_res_o = fsm_idle ? '0
                     : mul_hi   ? prod_hi_next
                                : prod_lo_next;

    // ------------------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------------------

    // Operands and command must be known while the product builds up
    op_known_a : assert property (
        @(posedge clk)
        acc_en_i |-> !$isunknown({op1_i, op2_i, cmd_i})
    ) else $error("IALU MUL: unknown operands or command during multiply");

endmodule : ialu_mul_datapath

`default_nettype wire

/* hdl/ialu_top.sv */
/*
 * IALU top level
 * Main adder, shift/logic unit and radix-2 multiplier with result select
 */

`timescale 1ns/100ps
`default_nettype none

module ialu_top
    import ialu_arch_pkg::*, ialu_cmd_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            cmd_valid_i,   // Multiply command valid
    input  wire ialu_cmd_e       cmd_i,
    input  wire logic [XLEN-1:0] op1_i,
    input  wire logic [XLEN-1:0] op2_i,
    output logic      [XLEN-1:0] res_o,         // ALU result
    output logic                 cmp_res_o,     // Comparison bit
    output logic                 res_rdy_o      // Result ready
);

    logic [XLEN-1:0] sum;               // Adder result
    logic            cmp;               // Adder comparison outcome
    logic [XLEN-1:0] shift_res;
    logic [XLEN-1:0] mul_res;
    logic            mul_cmd;
    mdu_state_e      mul_state;
    logic            iter_last;
    logic            acc_en;

    // ------------------------------------------------------------------------
    // Functional units
    // ------------------------------------------------------------------------

    ialu_main_adder #(.XLEN(XLEN)) i_main_adder (
        .op1_i (op1_i),
        .op2_i (op2_i),
        .cmd_i (cmd_i),
        .sum_o (sum),
        .cmp_o (cmp)
    );

    ialu_shift_logic #(.XLEN(XLEN)) i_shift_logic (
        .op1_i (op1_i),
        .op2_i (op2_i),
        .cmd_i (cmd_i),
        .res_o (shift_res)
    );

    assign mul_cmd = ialu_cmd_is_mul(cmd_i);   // One classification for control

    ialu_mul_ctrl #(.XLEN(XLEN)) i_mul_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid_i (cmd_valid_i),
        .mul_cmd_i   (mul_cmd),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .state_o     (mul_state),
        .iter_last_o (iter_last),
        .acc_en_o    (acc_en),
        .res_rdy_o   (res_rdy_o)
    );

    ialu_mul_datapath #(.XLEN(XLEN)) i_mul_datapath (
        .clk         (clk),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .cmd_i       (cmd_i),
        .state_i     (mul_state),
        .iter_last_i (iter_last),
        .acc_en_i    (acc_en),
        .mul_res_o   (mul_res)
    );

    // ------------------------------------------------------------------------
    // Result multiplexer
    // ------------------------------------------------------------------------

    always_comb begin
        case (cmd_i)
            IALU_CMD_ADD, IALU_CMD_SUB : res_o = sum;
            IALU_CMD_SUB_LT,  IALU_CMD_SUB_LTU,
            IALU_CMD_SUB_EQ,  IALU_CMD_SUB_NE,
            IALU_CMD_SUB_GE,  IALU_CMD_SUB_GEU : res_o = {{(XLEN-1){1'b0}}, cmp};
            IALU_CMD_AND, IALU_CMD_OR, IALU_CMD_XOR,
            IALU_CMD_SLL, IALU_CMD_SRL, IALU_CMD_SRA : res_o = shift_res;
            IALU_CMD_MUL,    IALU_CMD_MULH,
            IALU_CMD_MULHSU, IALU_CMD_MULHU : res_o = mul_res;
            default : res_o = '0;            // NONE
        endcase
    end

    assign cmp_res_o = cmp;                  // Already 0 outside comparisons

endmodule : ialu_top

`default_nettype wire

/* tests/ialu_tb_ref.svh */
/*
 * IALU testbench reference model
 * Expected result word and compare bit from command and operands
 */

`ifndef IALU_TB_REF_SVH
`define IALU_TB_REF_SVH

localparam int SHAMT_W = $clog2(XLEN);      // Shift amount bits taken from op2

// Returns {cmp_res_o, res_o}
function automatic logic [XLEN:0] alu_model(
    input ialu_cmd_e       cmd,
    input logic [XLEN-1:0] a,
    input logic [XLEN-1:0] b
);
    logic [2*XLEN-1:0]  ext_a;              // Double width operands
    logic [2*XLEN-1:0]  ext_b;
    logic [2*XLEN-1:0]  prod;               // Full product
    logic [SHAMT_W-1:0] sh;
    logic [XLEN-1:0]    res;
    logic               cmp;

    sh   = b[SHAMT_W-1:0];
    res  = '0;
    cmp  = 1'b0;
    prod = '0;
    if (ialu_cmd_is_mul(cmd)) begin
        // op1 unsigned only for MULHU, op2 signed only for MUL and MULH
        ext_a = {{XLEN{(cmd != IALU_CMD_MULHU) & a[XLEN-1]}}, a};
        ext_b = {{XLEN{((cmd == IALU_CMD_MUL) | (cmd == IALU_CMD_MULH)) & b[XLEN-1]}}, b};
        prod  = ext_a * ext_b;              // Wraps to 2*XLEN, sign handled by extension
    end

    case (cmd)
        IALU_CMD_AND     : res = a & b;
        IALU_CMD_OR      : res = a | b;
        IALU_CMD_XOR     : res = a ^ b;
        IALU_CMD_ADD     : res = a + b;
        IALU_CMD_SUB     : res = a - b;
        IALU_CMD_SUB_LT  : cmp = $signed(a) < $signed(b);
        IALU_CMD_SUB_LTU : cmp = a < b;
        IALU_CMD_SUB_EQ  : cmp = a == b;
        IALU_CMD_SUB_NE  : cmp = a != b;
        IALU_CMD_SUB_GE  : cmp = $signed(a) >= $signed(b);
        IALU_CMD_SUB_GEU : cmp = a >= b;
        IALU_CMD_SLL     : res = a << sh;
        IALU_CMD_SRL     : res = a >> sh;
        // Logical shift, then vacated bits filled with the sign
        IALU_CMD_SRA     : res = (a >> sh) | (a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0);
        IALU_CMD_MUL     : res = prod[XLEN-1:0];
        IALU_CMD_MULH, IALU_CMD_MULHSU, IALU_CMD_MULHU : res = prod[2*XLEN-1:XLEN];
        default          : res = '0;        // NONE
    endcase

    res |= XLEN'(cmp);                      // Compare bit doubles as word result
    return {cmp, res};
endfunction

`endif

/* tests/ialu_tb.sv */
/*
 * IALU testbench
 * Directed and random commands checked against a reference model
 */

`timescale 1ns/100ps
`default_nettype none

module ialu_tb
    import ialu_arch_pkg::*, ialu_cmd_pkg::*;
();

    localparam int XLEN        = XLEN_DEFAULT;
    localparam int CLK_HALF    = 2;                     // 4 ns period
    localparam int RST_CYCLES  = 5;
    localparam int N_RAND_ALU  = 300;
    localparam int N_RAND_MUL  = 48;
    // Commands issued in total, edge sets and abort included
    localparam int N_CMDS      = 128 + N_RAND_ALU + XLEN + 36 + N_RAND_MUL + 10;
    localparam int WATCHDOG_NS = (N_CMDS * (XLEN + 2) + 20) * 2 * CLK_HALF;

    localparam ialu_cmd_e ADD_CMP_CMDS [8] = '{IALU_CMD_ADD, IALU_CMD_SUB,
        IALU_CMD_SUB_LT, IALU_CMD_SUB_LTU, IALU_CMD_SUB_EQ, IALU_CMD_SUB_NE,
        IALU_CMD_SUB_GE, IALU_CMD_SUB_GEU};
    localparam ialu_cmd_e ALU_CMDS [15] = '{IALU_CMD_NONE, IALU_CMD_AND, IALU_CMD_OR,
        IALU_CMD_XOR, IALU_CMD_ADD, IALU_CMD_SUB, IALU_CMD_SUB_LT, IALU_CMD_SUB_LTU,
        IALU_CMD_SUB_EQ, IALU_CMD_SUB_NE, IALU_CMD_SUB_GE, IALU_CMD_SUB_GEU,
        IALU_CMD_SLL, IALU_CMD_SRL, IALU_CMD_SRA};
    localparam ialu_cmd_e MUL_CMDS [4] = '{IALU_CMD_MUL, IALU_CMD_MULH,
        IALU_CMD_MULHSU, IALU_CMD_MULHU};

    logic            clk = 1'b0;
    logic            rst_n;
    logic            cmd_valid;
    ialu_cmd_e       cmd_sel;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] res;
    logic            cmp_res;
    logic            res_rdy;
    logic [XLEN-1:0] edge_vals [4];                     // 0, all ones, most negative, 1
    int              seed = 23;
    int              n_checks = 0;

    `include "ialu_tb_ref.svh"

    ialu_top #(.XLEN(XLEN)) i_ialu_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd_sel),
        .op1_i       (op1),
        .op2_i       (op2),
        .res_o       (res),
        .cmp_res_o   (cmp_res),
        .res_rdy_o   (res_rdy)
    );

    always #(CLK_HALF) clk = ~clk;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(
        input string           name,
        input logic [XLEN-1:0] actual,
        input logic [XLEN-1:0] expected
    );
        n_checks++;
        if (actual !== expected) begin
            stop_on_failure($sformatf("ERROR: time %0t: %s = 0x%h, expected 0x%h (%s 0x%h 0x%h)",
                $time, name, actual, expected, cmd_sel.name(), op1, op2));
        end
    endtask

    function automatic logic [XLEN-1:0] rand_word();
        logic [XLEN+31:0] w;
        logic [31:0]      r;
        w = '0;
        for (int i = 0; i < (XLEN + 31) / 32; i++) begin
            r = $random(seed);
            w = {w[XLEN-1:0], r};                       // 32 bits per draw
        end
        return w[XLEN-1:0];
    endfunction

    function automatic logic [XLEN-1:0] rand_nonzero();
        logic [XLEN-1:0] w;
        w = rand_word();
        while (w == '0) w = rand_word();
        return w;
    endfunction

    // New inputs on the rising edge
    task automatic apply_cmd(
        input logic            valid,
        input ialu_cmd_e       c,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        @(posedge clk);
        cmd_valid <= valid;
        cmd_sel   <= c;
        op1       <= a;
        op2       <= b;
    endtask

    // Combinational commands are ready in the issue cycle
    task automatic run_alu(input ialu_cmd_e c, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        apply_cmd(1'b1, c, a, b);
        @(negedge clk);
        check_value("res_rdy_o", XLEN'(res_rdy), XLEN'(1));
    endtask

    // Issue, then count cycles until res_rdy_o
    task automatic run_mul(input ialu_cmd_e c, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        int cycles;
        int expected_cycles;
        cycles          = 0;
        expected_cycles = ((a != '0) && (b != '0)) ? XLEN - 1 : 0;
        apply_cmd(1'b1, c, a, b);
        @(negedge clk);                                 // Cycle 0
        while (!res_rdy && cycles < 2 * XLEN) begin
            @(negedge clk);
            cycles++;
        end
        if (!res_rdy) begin
            stop_on_failure("Multiply never raised res_rdy_o within 2*XLEN cycles");
        end
        check_value("res_rdy_o latency", XLEN'(cycles), XLEN'(expected_cycles));
    endtask

    // Valid dropped mid-way, command held
    task automatic run_abort(input ialu_cmd_e c, input int steps);
        apply_cmd(1'b1, c, rand_nonzero(), rand_nonzero());
        repeat (steps) begin
            @(negedge clk);
            check_value("res_rdy_o", XLEN'(res_rdy), '0);
        end
        apply_cmd(1'b0, c, op1, op2);
        repeat (2) begin
            @(negedge clk);
            check_value("res_rdy_o", XLEN'(res_rdy), '0);
        end
    endtask

    // ------------------------------------------------------------------------
    // Comparison, watchdog
    // ------------------------------------------------------------------------

    always @(negedge clk) begin : compare_results
        logic [XLEN:0] expected;
        if (rst_n && res_rdy) begin
            expected = alu_model(cmd_sel, op1, op2);
            check_value("res_o", res, expected[XLEN-1:0]);
            check_value("cmp_res_o", XLEN'(cmp_res), XLEN'(expected[XLEN]));
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        stop_on_failure($sformatf("Timeout: run still busy after %0d ns", WATCHDOG_NS));
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    initial begin : stimulus
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        int              idx;
        rst_n         = 1'b0;
        cmd_valid     = 1'b0;
        cmd_sel       = IALU_CMD_NONE;
        op1           = '0;
        op2           = '0;
        edge_vals[0]  = '0;
        edge_vals[1]  = '1;
        edge_vals[2]  = {1'b1, {(XLEN-1){1'b0}}};
        edge_vals[3]  = XLEN'(1);
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("res_rdy_o", XLEN'(res_rdy), XLEN'(1));    // Idle, valid low

        for (int c = 0; c < 8; c++)                             // Adder on edge operands
            for (int x = 0; x < 4; x++)
                for (int y = 0; y < 4; y++)
                    run_alu(ADD_CMP_CMDS[c], edge_vals[x], edge_vals[y]);

        for (int i = 0; i < N_RAND_ALU; i++) begin
            a   = rand_word();
            b   = rand_word();
            if (($random(seed) & 3) == 0) b = a;                // Hit EQ and GE paths
            idx = int'($unsigned($random(seed)) % 15);
            run_alu(ALU_CMDS[idx], a, b);
        end

        for (int i = 0; i < XLEN; i++) begin                    // SRA of negatives, every amount
            a                = rand_word();
            a[XLEN-1]        = 1'b1;
            b                = rand_word();
            b[SHAMT_W-1:0]   = SHAMT_W'(i);
            run_alu(IALU_CMD_SRA, a, b);
        end

        for (int c = 0; c < 4; c++)                             // Back to back, edge operands
            for (int x = 1; x < 4; x++)
                for (int y = 1; y < 4; y++)
                    run_mul(MUL_CMDS[c], edge_vals[x], edge_vals[y]);

        for (int i = 0; i < N_RAND_MUL; i++) begin
            run_mul(MUL_CMDS[i % 4], rand_nonzero(), rand_nonzero());
        end

        for (int c = 0; c < 4; c++) begin                       // Zero operand, no iteration
            run_mul(MUL_CMDS[c], '0, rand_nonzero());
            run_mul(MUL_CMDS[c], rand_nonzero(), '0);
        end

        run_abort(IALU_CMD_MULH, XLEN / 2);
        run_mul(IALU_CMD_MULHSU, rand_nonzero(), rand_nonzero());

        apply_cmd(1'b0, IALU_CMD_NONE, '0, '0);
        @(negedge clk);
        if (n_checks > 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_on_failure("No result was compared during the run");
        end
    end

endmodule : ialu_tb

`default_nettype wire

/* ialu.f */
+incdir+tests
hdl/ialu_arch_pkg.sv
hdl/ialu_cmd_pkg.sv
hdl/ialu_main_adder.sv
hdl/ialu_shift_logic.sv
hdl/ialu_mul_ctrl.sv
hdl/ialu_mul_datapath.sv
hdl/ialu_top.sv
tests/ialu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the IALU testbench with Verilator and runs it
# A failing run ends in $fatal, so the simulator exits nonzero
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module ialu_tb \
    -f ialu.f \
    -o ialu_tb_sim

./obj_dir/ialu_tb_sim
